// File: bench/id_stage_sva.sv
`timescale 1ns/1ps

module id_stage_sva import la_id_pkg::*; (
    input logic    clk,
    input logic    resetn,
    input logic    ds_allowin,
    input logic    ds2es_valid,
    input logic    es_allowin,
    input ds2es_t  ds2es_bus,
    input branch_t br
);

    // operands track the bypass ports so only instruction fields are held
    a_hold: assert property (@(posedge clk) disable iff (!resetn)
        ds2es_valid && !es_allowin |=> $stable(ds2es_bus.pc) && $stable(ds2es_bus.alu_op)
            && $stable(ds2es_bus.mem_op) && $stable(ds2es_bus.rf_waddr))
        else $error("held item changed while execute was busy");

    // taken branch leaves and the stage is empty after the edge
    a_br: assert property (@(posedge clk) disable iff (!resetn)
        br.taken |-> (ds2es_valid && es_allowin) ##1 (ds_allowin && !ds2es_valid))
        else $error("taken branch did not hand off and flush the stage");

    a_reset: assert property (@(posedge clk) $rose(resetn) |-> ds_allowin && !ds2es_valid)
        else $error("stage not idle after reset");

endmodule

bind id_stage id_stage_sva u_sva (.*);

// File: bench/id_model.svh
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// reference model over the shadow regfile and the bypass ports

function automatic logic [31:0] read_reg(input logic [4:0] a);
    if (a == 5'd0)
        return 32'd0;
    if (es_fwd.port.we && es_fwd.port.addr == a)
        return es_fwd.port.data;
    if (ms_fwd.we && ms_fwd.addr == a)
        return ms_fwd.data;
    if (ws_fwd.we && ws_fwd.addr == a)
        return ws_fwd.data;
    return shadow[a];
endfunction

function automatic decoded_t model_decode(input logic [31:0] inst);
    decoded_t d;
    logic [3:0] f;
    logic [4:0] s;
    logic [31:0] si12;
    logic [31:0] ui12;
    d = '0;
    f = inst[25:22];
    s = inst[19:15];
    si12 = {{20{inst[21]}}, inst[21:10]};
    ui12 = {20'd0, inst[21:10]};
    d.rj_addr = inst[9:5];
    d.r2_addr = inst[14:10];
    d.dest = inst[4:0];
    d.imm = ui12;
    if (inst[31:26] == `ID_OP_B || inst[31:26] == `ID_OP_BL)
        d.br_offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    else
        d.br_offs = {{14{inst[25]}}, inst[25:10], 2'b00};
    case (inst[31:26])
        `ID_OP_BASIC: begin
            d.reads_rj = 1'b1;
            d.gr_we = 1'b1;
            if (f == 4'h0) begin
                d.reads_r2 = 1'b1;
                d.alu_op.add = s == 5'h00;
                d.alu_op.sub = s == 5'h02;
                d.alu_op.slt = s == 5'h04;
                d.alu_op.sltu = s == 5'h05;
                d.alu_op.nor_op = s == 5'h08;
                d.alu_op.and_op = s == 5'h09;
                d.alu_op.or_op = s == 5'h0a;
                d.alu_op.xor_op = s == 5'h0b;
                d.alu_op.sll = s == 5'h0e;
                d.alu_op.srl = s == 5'h0f;
                d.alu_op.sra = s == 5'h10;
            end else begin
                d.src2_is_imm = 1'b1;
                d.imm = f >= 4'hd ? ui12 : si12; // andi, ori, xori zero-extend
                d.alu_op.sll = f == 4'h1 && s == 5'h01;
                d.alu_op.srl = f == 4'h1 && s == 5'h09;
                d.alu_op.sra = f == 4'h1 && s == 5'h11;
                d.alu_op.slt = f == 4'h8;
                d.alu_op.sltu = f == 4'h9;
                d.alu_op.add = f == 4'ha;
                d.alu_op.and_op = f == 4'hd;
                d.alu_op.or_op = f == 4'he;
                d.alu_op.xor_op = f == 4'hf;
            end
        end
        `ID_OP_LU12I, `ID_OP_PCADDU: begin
            d.alu_op.lui = inst[31:26] == `ID_OP_LU12I;
            d.alu_op.add = inst[31:26] == `ID_OP_PCADDU;
            d.src1_is_pc = inst[31:26] == `ID_OP_PCADDU;
            d.src2_is_imm = 1'b1;
            d.imm = {inst[24:5], 12'd0};
            d.gr_we = 1'b1;
        end
        `ID_OP_MEM: begin
            d.alu_op.add = 1'b1;
            d.reads_rj = 1'b1;
            d.src2_is_imm = 1'b1;
            d.imm = si12;
            d.mem_op = {f == 4'h0, f == 4'h8, f == 4'h1, f == 4'h9, f == 4'h2,
                        f == 4'h4, f == 4'h5, f == 4'h6};
            if (f >= 4'h4 && f <= 4'h6) begin
                d.reads_r2 = 1'b1; // store data comes from rd
                d.r2_addr = inst[4:0];
            end else begin
                d.gr_we = 1'b1;
            end
        end
        `ID_OP_JIRL, `ID_OP_BL: begin
            d.br_kind = inst[31:26] == `ID_OP_BL ? br_bl : br_jirl;
            d.reads_rj = inst[31:26] == `ID_OP_JIRL;
            d.alu_op.add = 1'b1;
            d.src1_is_pc = 1'b1;
            d.src2_is_imm = 1'b1;
            d.imm = 32'd4;
            d.gr_we = 1'b1;
            if (inst[31:26] == `ID_OP_BL)
                d.dest = 5'd1;
        end
        `ID_OP_B: d.br_kind = br_b;
        default: begin
            case (inst[31:26])
                `ID_OP_BEQ: d.br_kind = br_beq;
                `ID_OP_BNE: d.br_kind = br_bne;
                `ID_OP_BLT: d.br_kind = br_blt;
                `ID_OP_BGE: d.br_kind = br_bge;
                `ID_OP_BLTU: d.br_kind = br_bltu;
                default: d.br_kind = br_bgeu;
            endcase
            d.reads_rj = 1'b1;
            d.reads_r2 = 1'b1;
            d.r2_addr = inst[4:0];
        end
    endcase
    return d;
endfunction

function automatic ds2es_t model_bus(input decoded_t d, input logic [31:0] pc);
    ds2es_t e;
    e.alu_op = d.alu_op;
    e.res_from_mem = d.mem_op.ld_b | d.mem_op.ld_bu | d.mem_op.ld_h | d.mem_op.ld_hu
                   | d.mem_op.ld_w;
    e.alu_src1 = d.src1_is_pc ? pc : read_reg(d.rj_addr);
    e.alu_src2 = d.src2_is_imm ? d.imm : read_reg(d.r2_addr);
    e.rf_we = d.gr_we;
    e.rf_waddr = d.dest;
    e.rkd_value = read_reg(d.r2_addr);
    e.pc = pc;
    e.mem_op = d.mem_op;
    return e;
endfunction

// taken holds the branch condition alone
function automatic branch_t model_branch(input decoded_t d, input logic [31:0] pc);
    branch_t b;
    logic [31:0] a;
    logic [31:0] c;
    a = read_reg(d.rj_addr);
    c = read_reg(d.r2_addr);
    case (d.br_kind)
        br_beq: b.taken = a == c;
        br_bne: b.taken = a != c;
        br_blt: b.taken = $signed(a) < $signed(c);
        br_bge: b.taken = $signed(a) >= $signed(c);
        br_bltu: b.taken = a < c;
        br_bgeu: b.taken = a >= c;
        br_jirl, br_b, br_bl: b.taken = 1'b1;
        default: b.taken = 1'b0;
    endcase
    b.target = (d.br_kind == br_jirl ? a : pc) + d.br_offs;
    return b;
endfunction

function automatic logic load_use(input decoded_t d);
    if (!es_fwd.is_load || !es_fwd.port.we || es_fwd.port.addr == 5'd0)
        return 1'b0;
    return (d.reads_rj && es_fwd.port.addr == d.rj_addr)
        || (d.reads_r2 && es_fwd.port.addr == d.r2_addr);
endfunction

`endif

// File: bench/tb_id_stage.sv
`timescale 1ns/1ps
`include "la_id_defs.svh"

module tb_id_stage import la_id_pkg::*; ();

    localparam logic [4:0] ops_3r [11] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09,
                                           5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
    localparam logic [4:0] ops_shi [3] = '{5'h01, 5'h09, 5'h11};
    localparam logic [3:0] ops_imm [6] = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
    localparam logic [3:0] ops_mem [8] = '{4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h8, 4'h9};
    localparam logic [5:0] ops_br [6] = '{`ID_OP_BEQ, `ID_OP_BNE, `ID_OP_BLT,
                                          `ID_OP_BGE, `ID_OP_BLTU, `ID_OP_BGEU};

    logic       clk;
    logic       resetn;
    logic       fetch_valid;
    logic       ds_allowin;
    fetch_bus_t fetch_bus;
    logic       es_allowin;
    logic       ds2es_valid;
    ds2es_t     ds2es_bus;
    es_fwd_t    es_fwd;
    wb_port_t   ms_fwd;
    wb_port_t   ws_fwd;
    branch_t    br;

    logic [31:0] shadow [32];
    logic [31:0] rng;
    logic        checking;
    logic        m_valid = 1'b0; // model copy of the stage valid bit
    fetch_bus_t  m_cur;
    logic [31:0] pend_pc [$];  // fetched and not yet taken by execute
    int          mismatches = 0;
    int          other_errs = 0;
    int          timeout_errs = 0;

    `include "id_model.svh"

    id_stage u_id_stage (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] gen_inst();
        logic [31:0] r;
        logic [31:0] ins;
        int idx;
        r = next_rand();
        ins = next_rand();
        idx = r[27:24] % 11;
        ins[4:0] = {2'b00, r[2:0]}; // few registers so bypass hits are common
        ins[9:5] = {2'b00, r[5:3]};
        ins[14:10] = {2'b00, r[8:6]};
        case (r[31:28])
            4'd0, 4'd1: ins[31:15] = {`ID_OP_BASIC, 4'h0, 2'h1, ops_3r[idx]};
            4'd2: ins[31:15] = {`ID_OP_BASIC, 4'h1, 2'h0, ops_shi[idx % 3]};
            4'd3: ins[31:22] = {`ID_OP_BASIC, ops_imm[idx % 6]};
            4'd4: ins[31:25] = {`ID_OP_LU12I, 1'b0};
            4'd5: ins[31:25] = {`ID_OP_PCADDU, 1'b0};
            4'd6, 4'd7: ins[31:22] = {`ID_OP_MEM, ops_mem[idx % 8]};
            4'd8: ins[31:26] = `ID_OP_JIRL;
            4'd9: ins[31:26] = `ID_OP_B;
            4'd10: ins[31:26] = `ID_OP_BL;
            default: ins[31:26] = ops_br[idx % 6];
        endcase
        return ins;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        decoded_t d;
        ds2es_t e;
        branch_t b;
        logic st;
        logic v_exp;
        logic alw_exp;
        logic tk_exp;
        if (checking) begin
            d = model_decode(m_cur.inst);
            st = m_valid && load_use(d);
            v_exp = m_valid && !st;
            alw_exp = !m_valid || (!st && es_allowin);
            b = model_branch(d, m_cur.pc);
            tk_exp = v_exp && es_allowin && b.taken;
            check_val("ds_allowin", {31'd0, ds_allowin}, {31'd0, alw_exp});
            check_val("ds2es_valid", {31'd0, ds2es_valid}, {31'd0, v_exp});
            check_val("br.taken", {31'd0, br.taken}, {31'd0, tk_exp});
            if (tk_exp)
                check_val("br.target", br.target, b.target);
            if (v_exp) begin
                e = model_bus(d, m_cur.pc);
                check_val("alu_op", {20'd0, ds2es_bus.alu_op}, {20'd0, e.alu_op});
                check_val("mem_op", {24'd0, ds2es_bus.mem_op}, {24'd0, e.mem_op});
                check_val("res_from_mem", {31'd0, ds2es_bus.res_from_mem},
                          {31'd0, e.res_from_mem});
                check_val("alu_src1", ds2es_bus.alu_src1, e.alu_src1);
                check_val("alu_src2", ds2es_bus.alu_src2, e.alu_src2);
                check_val("rf_we", {31'd0, ds2es_bus.rf_we}, {31'd0, e.rf_we});
                check_val("rf_waddr", {27'd0, ds2es_bus.rf_waddr}, {27'd0, e.rf_waddr});
                check_val("rkd_value", ds2es_bus.rkd_value, e.rkd_value);
            end
            if (ds2es_valid && es_allowin) begin
                if (pend_pc.size() == 0) begin
                    other_errs++;
                    $display("item handed to execute with no fetched item pending at %0t",
                             $time);
                end else begin
                    check_val("accepted pc", ds2es_bus.pc, pend_pc.pop_front());
                end
            end
            // predict the coming edge
            if (fetch_valid && alw_exp && !tk_exp)
                pend_pc.push_back(fetch_bus.pc);
            if (tk_exp) begin
                m_valid = 1'b0;
            end else if (alw_exp) begin
                m_valid = fetch_valid;
                if (fetch_valid)
                    m_cur = fetch_bus;
            end
            if (ws_fwd.we && ws_fwd.addr != 5'd0)
                shadow[ws_fwd.addr] = ws_fwd.data;
        end
    end

    initial begin
        int n;
        logic [31:0] r;
        logic [31:0] pc_cnt;
        fetch_bus_t fb;
        rng = 32'h4146;
        pc_cnt = 32'h1c00_0000;
        resetn = 1'b0;
        checking = 1'b0;
        fetch_valid = 1'b0;
        fetch_bus = '0;
        es_allowin = 1'b0;
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        checking <= 1'b1;
        for (n = 1; n < 32; n++) begin
            @(posedge clk);
            ws_fwd <= '{we: 1'b1, addr: n[4:0], data: next_rand()};
        end
        for (n = 0; n < 3000; n++) begin
            @(posedge clk);
            r = next_rand();
            fb.inst = gen_inst();
            fb.pc = pc_cnt;
            pc_cnt = pc_cnt + 32'd4;
            fetch_valid <= r[1:0] != 2'b00;
            fetch_bus <= fb;
            es_allowin <= r[3:2] != 2'b00;
            es_fwd <= '{port: '{we: r[5:4] == 2'b00, addr: {2'b00, r[9:7]}, data: next_rand()},
                        is_load: r[10]};
            ms_fwd <= '{we: r[13:11] == 3'd0, addr: {2'b00, r[16:14]}, data: next_rand()};
            ws_fwd <= '{we: r[18:17] == 2'd0, addr: {2'b00, r[21:19]}, data: next_rand()};
        end
        @(posedge clk);
        fetch_valid <= 1'b0;
        es_allowin <= 1'b1;
        es_fwd <= '0;
        ms_fwd <= '0;
        ws_fwd <= '0;
        n = 0;
        while (pend_pc.size() != 0 && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (pend_pc.size() != 0) begin
            timeout_errs++;
            $display("timeout: %0d fetched items never reached execute", pend_pc.size());
        end
        @(negedge clk);
        $display("errors: %0d mismatches, %0d other", mismatches, other_errs + timeout_errs);
        if (mismatches == 0 && other_errs == 0 && timeout_errs == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: rtl/branch_unit.sv
`timescale 1ns/1ps
`include "la_id_defs.svh"

module branch_unit import la_id_pkg::*; (
    input  decoded_t            dec,
    input  logic [`ID_XLEN-1:0] pc,
    input  logic [`ID_XLEN-1:0] rj_value,
    input  logic [`ID_XLEN-1:0] rkd_value,
    input  logic                fire,
    output branch_t             br
);

    logic rj_eq;
    logic rj_lt;
    logic rj_ltu;
    logic cond;

    assign rj_eq  = rj_value == rkd_value;
    assign rj_lt  = $signed(rj_value) < $signed(rkd_value);
    assign rj_ltu = rj_value < rkd_value;

    always_comb begin
        case (dec.br_kind)
            br_beq:                 cond = rj_eq;
            br_bne:                 cond = !rj_eq;
            br_blt:                 cond = rj_lt;
            br_bge:                 cond = !rj_lt;
            br_bltu:                cond = rj_ltu;
            br_bgeu:                cond = !rj_ltu;
            br_jirl, br_b, br_bl:   cond = 1'b1; // unconditional
            default:                cond = 1'b0;
        endcase
    end

    // only redirect once the branch itself is accepted by execute
    assign br.taken  = fire && cond;
    assign br.target = (dec.br_kind == br_jirl ? rj_value : pc) + dec.br_offs;

endmodule

// File: rtl/id_pipe_ctrl.sv
`timescale 1ns/1ps

module id_pipe_ctrl import la_id_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       fetch_valid,
    input  fetch_bus_t fetch_bus,
    input  logic       es_allowin,
    input  logic       stall,
    input  logic       br_taken,
    output logic       ds_allowin,
    output logic       ds2es_valid,
    output logic       ds_valid,
    output fetch_bus_t cur
);

    logic ready_go;

    assign ready_go    = ~stall;
    assign ds_allowin  = ~ds_valid | (ready_go & es_allowin);
    assign ds2es_valid = ds_valid & ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (br_taken) begin
            ds_valid <= 1'b0; // wrong-path fetch item dropped
        end else if (ds_allowin) begin
            ds_valid <= fetch_valid;
        end
    end

    // fetch payload latched on transfer
    always_ff @(posedge clk) begin
        if (fetch_valid && ds_allowin) begin
            cur <= fetch_bus;
        end
    end

endmodule

// File: rtl/id_stage.sv
`timescale 1ns/1ps
`include "la_id_defs.svh"

module id_stage import la_id_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       fetch_valid,
    output logic       ds_allowin,
    input  fetch_bus_t fetch_bus,
    input  logic       es_allowin,
    output logic       ds2es_valid,
    output ds2es_t     ds2es_bus,
    input  es_fwd_t    es_fwd,
    input  wb_port_t   ms_fwd,
    input  wb_port_t   ws_fwd,
    output branch_t    br
);

    logic                ds_valid;
    logic                stall;
    logic                fire;
    fetch_bus_t          cur;
    decoded_t            dec;
    logic [`ID_XLEN-1:0] rj_value;
    logic [`ID_XLEN-1:0] rkd_value;
    logic [`ID_XLEN-1:0] alu_src1;
    logic [`ID_XLEN-1:0] alu_src2;

    assign fire = ds2es_valid & es_allowin; // item leaves this edge

    id_pipe_ctrl u_pipe_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .fetch_valid (fetch_valid),
        .fetch_bus   (fetch_bus),
        .es_allowin  (es_allowin),
        .stall       (stall),
        .br_taken    (br.taken),
        .ds_allowin  (ds_allowin),
        .ds2es_valid (ds2es_valid),
        .ds_valid    (ds_valid),
        .cur         (cur)
    );

    inst_decoder u_decoder (
        .inst (cur.inst),
        .dec  (dec)
    );

    operand_fetch u_operand_fetch (
        .clk       (clk),
        .dec       (dec),
        .pc        (cur.pc),
        .ds_valid  (ds_valid),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .ws_fwd    (ws_fwd),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .alu_src1  (alu_src1),
        .alu_src2  (alu_src2),
        .stall     (stall)
    );

    branch_unit u_branch_unit (
        .dec       (dec),
        .pc        (cur.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .fire      (fire),
        .br        (br)
    );

    always_comb begin
        ds2es_bus.alu_op       = dec.alu_op;
        ds2es_bus.res_from_mem = dec.mem_op.ld_b | dec.mem_op.ld_bu | dec.mem_op.ld_h
                               | dec.mem_op.ld_hu | dec.mem_op.ld_w;
        ds2es_bus.alu_src1     = alu_src1;
        ds2es_bus.alu_src2     = alu_src2;
        ds2es_bus.rf_we        = dec.gr_we;
        ds2es_bus.rf_waddr     = dec.dest;
        ds2es_bus.rkd_value    = rkd_value;
        ds2es_bus.pc           = cur.pc;
        ds2es_bus.mem_op       = dec.mem_op;
    end

endmodule

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
`include "la_id_defs.svh"

module inst_decoder import la_id_pkg::*; (
    input  logic [`ID_XLEN-1:0] inst,
    output decoded_t            dec
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    logic is_basic;
    logic is_3r;   // three register ops
    logic is_shi;  // shift by 5-bit imm
    logic is_mem;
    logic inst_slti, inst_sltui, inst_addi;
    logic inst_andi, inst_ori, inst_xori;
    logic inst_lu12i, inst_pcaddu;
    logic any_ld, any_st;
    logic need_si12, need_ui12, need_si20, src2_is_4;
    logic cond_br;
    logic jump_link; // jirl and bl write pc+4

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i16      = inst[25:10];
    assign i20      = inst[24:5];
    assign i26      = {inst[9:0], inst[25:10]};

    assign is_basic = op_31_26 == `ID_OP_BASIC;
    assign is_3r    = is_basic && op_25_22 == 4'h0 && op_21_20 == 2'h1;
    assign is_shi   = is_basic && op_25_22 == 4'h1 && op_21_20 == 2'h0;
    assign is_mem   = op_31_26 == `ID_OP_MEM;

    assign inst_slti   = is_basic && op_25_22 == 4'h8;
    assign inst_sltui  = is_basic && op_25_22 == 4'h9;
    assign inst_addi   = is_basic && op_25_22 == 4'ha;
    assign inst_andi   = is_basic && op_25_22 == 4'hd;
    assign inst_ori    = is_basic && op_25_22 == 4'he;
    assign inst_xori   = is_basic && op_25_22 == 4'hf;
    assign inst_lu12i  = op_31_26 == `ID_OP_LU12I && !inst[25];
    assign inst_pcaddu = op_31_26 == `ID_OP_PCADDU && !inst[25];

    always_comb begin
        dec = '0;

        dec.alu_op.add    = (is_3r && op_19_15 == 5'h00) || inst_addi || inst_pcaddu;
        dec.alu_op.sub    = is_3r && op_19_15 == 5'h02;
        dec.alu_op.slt    = (is_3r && op_19_15 == 5'h04) || inst_slti;
        dec.alu_op.sltu   = (is_3r && op_19_15 == 5'h05) || inst_sltui;
        dec.alu_op.nor_op = is_3r && op_19_15 == 5'h08;
        dec.alu_op.and_op = (is_3r && op_19_15 == 5'h09) || inst_andi;
        dec.alu_op.or_op  = (is_3r && op_19_15 == 5'h0a) || inst_ori;
        dec.alu_op.xor_op = (is_3r && op_19_15 == 5'h0b) || inst_xori;
        dec.alu_op.sll    = (is_3r && op_19_15 == 5'h0e) || (is_shi && op_19_15 == 5'h01);
        dec.alu_op.srl    = (is_3r && op_19_15 == 5'h0f) || (is_shi && op_19_15 == 5'h09);
        dec.alu_op.sra    = (is_3r && op_19_15 == 5'h10) || (is_shi && op_19_15 == 5'h11);
        dec.alu_op.lui    = inst_lu12i;

        dec.mem_op.ld_b  = is_mem && op_25_22 == 4'h0;
        dec.mem_op.ld_h  = is_mem && op_25_22 == 4'h1;
        dec.mem_op.ld_w  = is_mem && op_25_22 == 4'h2;
        dec.mem_op.st_b  = is_mem && op_25_22 == 4'h4;
        dec.mem_op.st_h  = is_mem && op_25_22 == 4'h5;
        dec.mem_op.st_w  = is_mem && op_25_22 == 4'h6;
        dec.mem_op.ld_bu = is_mem && op_25_22 == 4'h8;
        dec.mem_op.ld_hu = is_mem && op_25_22 == 4'h9;

        case (op_31_26)
            `ID_OP_JIRL: dec.br_kind = br_jirl;
            `ID_OP_B:    dec.br_kind = br_b;
            `ID_OP_BL:   dec.br_kind = br_bl;
            `ID_OP_BEQ:  dec.br_kind = br_beq;
            `ID_OP_BNE:  dec.br_kind = br_bne;
            `ID_OP_BLT:  dec.br_kind = br_blt;
            `ID_OP_BGE:  dec.br_kind = br_bge;
            `ID_OP_BLTU: dec.br_kind = br_bltu;
            `ID_OP_BGEU: dec.br_kind = br_bgeu;
            default:     dec.br_kind = br_none;
        endcase

        any_ld    = |{dec.mem_op.ld_b, dec.mem_op.ld_bu, dec.mem_op.ld_h,
                      dec.mem_op.ld_hu, dec.mem_op.ld_w};
        any_st    = |{dec.mem_op.st_b, dec.mem_op.st_h, dec.mem_op.st_w};
        cond_br   = op_31_26 >= `ID_OP_BEQ && op_31_26 <= `ID_OP_BGEU;
        jump_link = dec.br_kind == br_jirl || dec.br_kind == br_bl;

        // loads, stores, jirl and bl go through the adder
        dec.alu_op.add = dec.alu_op.add || any_ld || any_st || jump_link;

        need_si12 = is_shi || inst_slti || inst_sltui || inst_addi || any_ld || any_st;
        need_ui12 = inst_andi || inst_ori || inst_xori;
        need_si20 = inst_lu12i || inst_pcaddu;
        src2_is_4 = jump_link;

        if (src2_is_4)
            dec.imm = 32'd4;
        else if (need_si20)
            dec.imm = {i20, 12'b0};
        else if (need_si12)
            dec.imm = {{20{i12[11]}}, i12};
        else
            dec.imm = {20'b0, i12};

        if (dec.br_kind == br_b || dec.br_kind == br_bl)
            dec.br_offs = {{4{i26[25]}}, i26, 2'b0};
        else
            dec.br_offs = {{14{i16[15]}}, i16, 2'b0};

        dec.src1_is_pc  = jump_link || inst_pcaddu;
        dec.src2_is_imm = need_si12 || need_ui12 || need_si20 || src2_is_4;
        dec.reads_rj    = is_3r || need_si12 || need_ui12 || cond_br
                       || dec.br_kind == br_jirl;
        dec.reads_r2    = is_3r || any_st || cond_br;
        dec.r2_addr     = (any_st || cond_br) ? rd : rk;
        dec.rj_addr     = rj;
        dec.gr_we       = is_3r || need_ui12 || need_si20 || jump_link
                       || (need_si12 && !any_st);
        dec.dest        = dec.br_kind == br_bl ? 5'd1 : rd;
    end

endmodule

// File: rtl/la_id_defs.svh
`ifndef LA_ID_DEFS_SVH
`define LA_ID_DEFS_SVH

// datapath widths
`define ID_XLEN   32
`define ID_REG_AW 5
`define ID_NREGS  32

// major opcode in inst[31:26]
`define ID_OP_BASIC  6'h00 // 3r ops, shifts by imm, 12-bit imm ops
`define ID_OP_LU12I  6'h05
`define ID_OP_PCADDU 6'h07
`define ID_OP_MEM    6'h0a // loads and stores with kind in inst[25:22]
`define ID_OP_JIRL   6'h13
`define ID_OP_B      6'h14
`define ID_OP_BL     6'h15
`define ID_OP_BEQ    6'h16
`define ID_OP_BNE    6'h17
`define ID_OP_BLT    6'h18
`define ID_OP_BGE    6'h19
`define ID_OP_BLTU   6'h1a
`define ID_OP_BGEU   6'h1b

`endif

// File: rtl/la_id_pkg.sv
`include "la_id_defs.svh"

package la_id_pkg;

    typedef struct packed {
        logic [`ID_XLEN-1:0] inst;
        logic [`ID_XLEN-1:0] pc;
    } fetch_bus_t;

    // one later stage writing back
    typedef struct packed {
        logic                  we;
        logic [`ID_REG_AW-1:0] addr;
        logic [`ID_XLEN-1:0]   data;
    } wb_port_t;

    typedef struct packed {
        wb_port_t port;
        logic     is_load; // data not ready yet
    } es_fwd_t;

    typedef struct packed {
        logic add;
        logic sub;
        logic slt;
        logic sltu;
        logic and_op;
        logic nor_op;
        logic or_op;
        logic xor_op;
        logic sll;
        logic srl;
        logic sra;
        logic lui;
    } alu_op_t;

    typedef struct packed {
        logic ld_b;
        logic ld_bu;
        logic ld_h;
        logic ld_hu;
        logic ld_w;
        logic st_b;
        logic st_h;
        logic st_w;
    } mem_op_t;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_jirl,
        br_b,
        br_bl
    } br_kind_t;

    typedef struct packed {
        alu_op_t               alu_op;
        mem_op_t               mem_op;
        br_kind_t              br_kind;
        logic [`ID_XLEN-1:0]   br_offs;
        logic [`ID_XLEN-1:0]   imm;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  reads_rj;
        logic                  reads_r2;
        logic [`ID_REG_AW-1:0] r2_addr; // rd for branches and stores
        logic [`ID_REG_AW-1:0] rj_addr;
        logic                  gr_we;
        logic [`ID_REG_AW-1:0] dest;
    } decoded_t;

    typedef struct packed {
        logic                taken;
        logic [`ID_XLEN-1:0] target;
    } branch_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  res_from_mem;
        logic [`ID_XLEN-1:0]   alu_src1;
        logic [`ID_XLEN-1:0]   alu_src2;
        logic                  rf_we;
        logic [`ID_REG_AW-1:0] rf_waddr;
        logic [`ID_XLEN-1:0]   rkd_value; // store data
        logic [`ID_XLEN-1:0]   pc;
        mem_op_t               mem_op;
    } ds2es_t;

endpackage

// File: rtl/operand_fetch.sv
`timescale 1ns/1ps
`include "la_id_defs.svh"

module operand_fetch import la_id_pkg::*; (
    input  logic                clk,
    input  decoded_t            dec,
    input  logic [`ID_XLEN-1:0] pc,
    input  logic                ds_valid,
    input  es_fwd_t             es_fwd,
    input  wb_port_t            ms_fwd,
    input  wb_port_t            ws_fwd,
    output logic [`ID_XLEN-1:0] rj_value,
    output logic [`ID_XLEN-1:0] rkd_value,
    output logic [`ID_XLEN-1:0] alu_src1,
    output logic [`ID_XLEN-1:0] alu_src2,
    output logic                stall
);

    logic [`ID_XLEN-1:0] rf_rdata1;
    logic [`ID_XLEN-1:0] rf_rdata2;
    logic                es_hit_rj;
    logic                es_hit_r2;

    function automatic logic hit(wb_port_t p, logic [`ID_REG_AW-1:0] addr);
        return p.we && (addr != '0) && (p.addr == addr);
    endfunction

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.rj_addr),
        .raddr2 (dec.r2_addr),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (ws_fwd.we),
        .waddr  (ws_fwd.addr),
        .wdata  (ws_fwd.data)
    );

    assign es_hit_rj = hit(es_fwd.port, dec.rj_addr);
    assign es_hit_r2 = hit(es_fwd.port, dec.r2_addr);

    // youngest producer wins
    assign rj_value  = es_hit_rj                   ? es_fwd.port.data :
                       hit(ms_fwd, dec.rj_addr)    ? ms_fwd.data :
                       hit(ws_fwd, dec.rj_addr)    ? ws_fwd.data : rf_rdata1;
    assign rkd_value = es_hit_r2                   ? es_fwd.port.data :
                       hit(ms_fwd, dec.r2_addr)    ? ms_fwd.data :
                       hit(ws_fwd, dec.r2_addr)    ? ws_fwd.data : rf_rdata2;

    // load result not available until mem stage
    assign stall = ds_valid && es_fwd.is_load
                && ((dec.reads_rj && es_hit_rj) || (dec.reads_r2 && es_hit_r2));

    assign alu_src1 = dec.src1_is_pc  ? pc      : rj_value;
    assign alu_src2 = dec.src2_is_imm ? dec.imm : rkd_value;

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps
`include "la_id_defs.svh"

module regfile (
    input  logic                  clk,
    input  logic [`ID_REG_AW-1:0] raddr1,
    input  logic [`ID_REG_AW-1:0] raddr2,
    output logic [`ID_XLEN-1:0]   rdata1,
    output logic [`ID_XLEN-1:0]   rdata2,
    input  logic                  we,
    input  logic [`ID_REG_AW-1:0] waddr,
    input  logic [`ID_XLEN-1:0]   wdata
);

    logic [`ID_XLEN-1:0] rf [`ID_NREGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1]; // r0 hard zero
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_id_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_id_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^\*\* PASS \*\*$" sim.log; then
    exit 0
fi
exit 1

// File: tb.f
+incdir+rtl
+incdir+bench
rtl/la_id_pkg.sv
rtl/regfile.sv
rtl/id_pipe_ctrl.sv
rtl/inst_decoder.sv
rtl/operand_fetch.sv
rtl/branch_unit.sv
rtl/id_stage.sv
bench/id_stage_sva.sv
bench/tb_id_stage.sv
